/* bp_settings.svh */
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// global and choice table index width
// kept at 8 for short sweeps, 14 in the full-size fetch unit
`define BP_GH_WIDTH 8

// bimodal table index width
`define BP_BH_WIDTH 8

// fetch address width
`define BP_ADDR_WIDTH 30

// sweep covers the larger of the two tables
`define BP_SWEEP_WIDTH ((`BP_GH_WIDTH > `BP_BH_WIDTH) ? `BP_GH_WIDTH : `BP_BH_WIDTH)

// weakly not taken
`define BP_DIR_INIT 2'b01

// weakly bimodal
`define BP_CHOICE_INIT 2'b01

`endif

/* bp_pkg.sv */
package bp_pkg;

    // branch class as decoded by the fetch stage
    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1,
        JUMP          = 3'd2,
        CALL          = 3'd3,
        RET           = 3'd4,
        INDIRECT_JUMP = 3'd5,
        OTHER_JUMP    = 3'd6
    } br_kind_e;

    // 2-bit saturating counter
    // msb is the prediction: taken for direction tables,
    // use global for the choice table
    typedef logic [1:0] sat_ctr_t;

endpackage

/* bp_pht.sv */
`timescale 1ns/10ps

module bp_pht #(
    parameter int               idx_width = 8,
    parameter bp_pkg::sat_ctr_t init_val  = 2'b01
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // prediction read
    input  logic [idx_width-1:0] hashed_pc,
    output bp_pkg::sat_ctr_t     ctr_pdc,
    // training write
    input  logic [idx_width-1:0] hashed_pc_update,
    input  logic                 outcome,
    input  logic                 update_en,
    // init sweep write
    input  logic                 init_en,
    input  logic [idx_width-1:0] init_index
);
    import bp_pkg::*;

    // counter storage, no reset, filled by the init sweep
    sat_ctr_t ctr_mem [2**idx_width];

    sat_ctr_t ctr_upd;
    sat_ctr_t ctr_next;

    // async read for same-cycle prediction
    assign ctr_pdc = ctr_mem[hashed_pc];

    // current value at the training index
    assign ctr_upd = ctr_mem[hashed_pc_update];

    // saturating step toward the real outcome
    always_comb begin
        ctr_next = ctr_upd;
        if (outcome && (ctr_upd != '1)) begin
            ctr_next = ctr_upd + 2'd1;
        end else if (!outcome && (ctr_upd != '0)) begin
            ctr_next = ctr_upd - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        // init sweep wins over training
        if (init_en) begin
            ctr_mem[init_index] <= init_val;
        end else if (rst_n && update_en) begin
            // training held off while in reset
            ctr_mem[hashed_pc_update] <= ctr_next;
        end
    end

endmodule

/* bp_sweep_counter.sv */
`timescale 1ns/10ps

module bp_sweep_counter #(
    parameter int width = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             sweep_en,
    output logic [width-1:0] sweep_index,
    output logic             sweep_last
);

    // walks 0 .. 2**width-1, one step per enabled cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sweep_index <= '0;
        end else if (sweep_en) begin
            // wraps after the last index, fsm has left the sweep by then
            sweep_index <= sweep_index + 1'b1;
        end
    end

    // last index reached when all ones
    assign sweep_last = &sweep_index;

endmodule

/* bp_init_fsm.sv */
`timescale 1ns/10ps

module bp_init_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic sweep_last,
    output logic sweep_en,
    output logic init_en,
    output logic train_ok,
    output logic ready
);

    typedef enum logic {
        SWEEP = 1'b0,
        RUN   = 1'b1
    } init_state_e;

    init_state_e state;
    init_state_e state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= SWEEP;
        end else begin
            state <= state_next;
        end
    end

    // one-way trip: sweep once after reset, then run for good
    always_comb begin
        state_next = state;
        case (state)
            SWEEP: begin
                if (sweep_last) begin
                    state_next = RUN;
                end
            end
            default: state_next = RUN;
        endcase
    end

    // sweep drives the counter and the table init ports
    assign sweep_en = (state == SWEEP);
    assign init_en  = (state == SWEEP);

    // training and ready only once tables hold known values
    assign train_ok = (state == RUN);
    assign ready    = (state == RUN);

endmodule

/* aim_predictor.sv */
`timescale 1ns/10ps
`include "bp_settings.svh"

module aim_predictor #(
    parameter int gh_width    = `BP_GH_WIDTH,
    parameter int bh_width    = `BP_BH_WIDTH,
    parameter int addr_width  = `BP_ADDR_WIDTH,
    parameter int sweep_width = `BP_SWEEP_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   update_en,
    // execute side
    input  logic [addr_width-1:0]  pc_ex,
    input  logic [gh_width-1:0]    pc_ex_gh_hashed,
    input  logic [bh_width-1:0]    pc_ex_bh_hashed,
    input  bp_pkg::br_kind_e       kind_ex,
    input  logic                   choice_real,
    input  logic                   taken_real,
    // prediction
    input  bp_pkg::br_kind_e       kind_pdc,
    output logic                   taken_pdc,
    // 0 bimodal, 1 global
    output logic                   choice_b_g,
    // current fetch
    input  logic [gh_width-1:0]    pc_gh_hashed,
    input  logic [bh_width-1:0]    pc_bh_hashed,
    input  logic [addr_width-1:0]  pc,
    // init sweep and training gate
    input  logic                   train_ok,
    input  logic                   init_en,
    input  logic [sweep_width-1:0] init_index
);
    import bp_pkg::*;

    // pc and pc_ex ride along with the hashes, indexing uses the hashed values only

    sat_ctr_t ctr_b;
    sat_ctr_t ctr_g;
    sat_ctr_t ctr_c;
    logic     taken_b;
    logic     taken_g;
    logic     train_en;

    // only resolved direct branches train, and only after the sweep
    assign train_en = train_ok && update_en && (kind_ex == DIRECT_JUMP);

    // bimodal table, pc-only index
    bp_pht #(
        .idx_width (bh_width),
        .init_val  (`BP_DIR_INIT)
    ) bpht_b (
        .clk              (clk),
        .rst_n            (rst_n),
        .hashed_pc        (pc_bh_hashed),
        .ctr_pdc          (ctr_b),
        .hashed_pc_update (pc_ex_bh_hashed),
        .outcome          (taken_real),
        .update_en        (train_en),
        .init_en          (init_en),
        .init_index       (init_index[bh_width-1:0])
    );

    // global table, pc xor history index
    bp_pht #(
        .idx_width (gh_width),
        .init_val  (`BP_DIR_INIT)
    ) gpht_g (
        .clk              (clk),
        .rst_n            (rst_n),
        .hashed_pc        (pc_gh_hashed),
        .ctr_pdc          (ctr_g),
        .hashed_pc_update (pc_ex_gh_hashed),
        .outcome          (taken_real),
        .update_en        (train_en),
        .init_en          (init_en),
        .init_index       (init_index[gh_width-1:0])
    );

    // choice table shares the global index
    // trained toward whichever table was right
    bp_pht #(
        .idx_width (gh_width),
        .init_val  (`BP_CHOICE_INIT)
    ) cpht_b_g (
        .clk              (clk),
        .rst_n            (rst_n),
        .hashed_pc        (pc_gh_hashed),
        .ctr_pdc          (ctr_c),
        .hashed_pc_update (pc_ex_gh_hashed),
        .outcome          (choice_real),
        .update_en        (train_en),
        .init_en          (init_en),
        .init_index       (init_index[gh_width-1:0])
    );

    // counter msb is the prediction
    assign taken_b    = ctr_b[1];
    assign taken_g    = ctr_g[1];
    assign choice_b_g = ctr_c[1];

    // unconditional kinds fixed, direct jumps go through the tournament
    always_comb begin
        case (kind_pdc)
            NOT_JUMP:      taken_pdc = 1'b0;
            DIRECT_JUMP:   taken_pdc = choice_b_g ? taken_g : taken_b;
            JUMP:          taken_pdc = 1'b1;
            CALL:          taken_pdc = 1'b1;
            RET:           taken_pdc = 1'b1;
            INDIRECT_JUMP: taken_pdc = 1'b1;
            // other_jump and unknown codes fall through
            default:       taken_pdc = 1'b0;
        endcase
    end

endmodule

/* bp_top.sv */
`timescale 1ns/10ps
`include "bp_settings.svh"

module bp_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // current fetch
    input  logic [`BP_ADDR_WIDTH-1:0]  pc,
    input  logic [`BP_GH_WIDTH-1:0]    pc_gh_hashed,
    input  logic [`BP_BH_WIDTH-1:0]    pc_bh_hashed,
    input  bp_pkg::br_kind_e           kind_pdc,
    // execute
    input  logic [`BP_ADDR_WIDTH-1:0]  pc_ex,
    input  logic [`BP_GH_WIDTH-1:0]    pc_ex_gh_hashed,
    input  logic [`BP_BH_WIDTH-1:0]    pc_ex_bh_hashed,
    input  bp_pkg::br_kind_e           kind_ex,
    input  logic                       choice_real,
    input  logic                       taken_real,
    input  logic                       update_en,
    // results
    output logic                       taken_pdc,
    output logic                       choice_b_g,
    output logic                       ready
);

    logic                       sweep_en;
    logic                       sweep_last;
    logic [`BP_SWEEP_WIDTH-1:0] sweep_index;
    logic                       init_en;
    logic                       train_ok;

    // reset-time table fill control
    bp_init_fsm u_init_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .sweep_last (sweep_last),
        .sweep_en   (sweep_en),
        .init_en    (init_en),
        .train_ok   (train_ok),
        .ready      (ready)
    );

    // index source for the sweep
    bp_sweep_counter #(
        .width (`BP_SWEEP_WIDTH)
    ) u_sweep_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .sweep_en    (sweep_en),
        .sweep_index (sweep_index),
        .sweep_last  (sweep_last)
    );

    aim_predictor u_aim_predictor (
        .clk             (clk),
        .rst_n           (rst_n),
        .update_en       (update_en),
        .pc_ex           (pc_ex),
        .pc_ex_gh_hashed (pc_ex_gh_hashed),
        .pc_ex_bh_hashed (pc_ex_bh_hashed),
        .kind_ex         (kind_ex),
        .choice_real     (choice_real),
        .taken_real      (taken_real),
        .kind_pdc        (kind_pdc),
        .taken_pdc       (taken_pdc),
        .choice_b_g      (choice_b_g),
        .pc_gh_hashed    (pc_gh_hashed),
        .pc_bh_hashed    (pc_bh_hashed),
        .pc              (pc),
        .train_ok        (train_ok),
        .init_en         (init_en),
        .init_index      (sweep_index)
    );

endmodule

/* bp_asserts.sv */
`timescale 1ns/10ps
`include "bp_settings.svh"

module bp_asserts (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`BP_GH_WIDTH-1:0]  pc_gh_hashed,
    input  logic [`BP_BH_WIDTH-1:0]  pc_bh_hashed,
    input  bp_pkg::br_kind_e         kind_pdc,
    input  logic [`BP_GH_WIDTH-1:0]  pc_ex_gh_hashed,
    input  logic [`BP_BH_WIDTH-1:0]  pc_ex_bh_hashed,
    input  bp_pkg::br_kind_e         kind_ex,
    input  logic                     choice_real,
    input  logic                     taken_real,
    input  logic                     update_en,
    input  logic                     taken_pdc,
    input  logic                     choice_b_g,
    input  logic                     ready
);
    import bp_pkg::*;

    // read by the testbench to spot a failed check
    int fail_count;

    // shadow tables
    sat_ctr_t bim_mdl [2**`BP_BH_WIDTH];
    sat_ctr_t glob_mdl [2**`BP_GH_WIDTH];
    sat_ctr_t cho_mdl [2**`BP_GH_WIDTH];

    logic [`BP_SWEEP_WIDTH-1:0] sweep_cnt;
    logic                       model_ready;
    logic                       model_train;
    logic                       exp_taken;
    logic                       exp_choice;

    // one step toward the outcome, pinned at 0 and 3
    function automatic sat_ctr_t sat_step(input sat_ctr_t c, input logic up);
        if (up) begin
            return (c == 2'd3) ? 2'd3 : c + 2'd1;
        end
        return (c == 2'd0) ? 2'd0 : c - 2'd1;
    endfunction

    assign model_train = model_ready && update_en && (kind_ex == DIRECT_JUMP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // tables end the sweep at their init values
            for (int i = 0; i < 2**`BP_BH_WIDTH; i++) begin
                bim_mdl[i] <= `BP_DIR_INIT;
            end
            for (int i = 0; i < 2**`BP_GH_WIDTH; i++) begin
                glob_mdl[i] <= `BP_DIR_INIT;
                cho_mdl[i]  <= `BP_CHOICE_INIT;
            end
            sweep_cnt   <= '0;
            model_ready <= 1'b0;
        end else if (!model_ready) begin
            // one index per cycle, ready the cycle after the last one
            if (sweep_cnt == '1) begin
                model_ready <= 1'b1;
            end else begin
                sweep_cnt <= sweep_cnt + 1'b1;
            end
        end else if (model_train) begin
            bim_mdl[pc_ex_bh_hashed]  <= sat_step(bim_mdl[pc_ex_bh_hashed], taken_real);
            glob_mdl[pc_ex_gh_hashed] <= sat_step(glob_mdl[pc_ex_gh_hashed], taken_real);
            cho_mdl[pc_ex_gh_hashed]  <= sat_step(cho_mdl[pc_ex_gh_hashed], choice_real);
        end
    end

    // expected outputs from the shadow tables
    always_comb begin
        exp_choice = cho_mdl[pc_gh_hashed][1];
        case (kind_pdc)
            JUMP, CALL, RET, INDIRECT_JUMP: exp_taken = 1'b1;
            DIRECT_JUMP: begin
                exp_taken = exp_choice ? glob_mdl[pc_gh_hashed][1] : bim_mdl[pc_bh_hashed][1];
            end
            default: exp_taken = 1'b0;
        endcase
    end

    a_ready_match: assert property (@(posedge clk) disable iff (!rst_n)
        ready == model_ready)
        else begin
            fail_count++;
            $error("Error at time %0t: ready is %0b, expected %0b", $time,
                   $sampled(ready), $sampled(model_ready));
        end

    // ready never drops once up
    a_ready_holds: assert property (@(posedge clk) disable iff (!rst_n)
        ready |=> ready)
        else begin
            fail_count++;
            $error("Error at time %0t: ready fell after rising", $time);
        end

    // unconditional kinds ignore the tables
    a_fixed_kinds: assert property (@(posedge clk) disable iff (!rst_n)
        (model_ready && kind_pdc inside {JUMP, CALL, RET, INDIRECT_JUMP}) |-> taken_pdc)
        else begin
            fail_count++;
            $error("Error at time %0t: kind %0d predicted not taken", $time,
                   $sampled(kind_pdc));
        end

    a_taken_match: assert property (@(posedge clk) disable iff (!rst_n)
        model_ready |-> (taken_pdc == exp_taken))
        else begin
            fail_count++;
            $error("Error at time %0t: taken_pdc is %0b, expected %0b", $time,
                   $sampled(taken_pdc), $sampled(exp_taken));
        end

    a_choice_match: assert property (@(posedge clk) disable iff (!rst_n)
        model_ready |-> (choice_b_g == exp_choice))
        else begin
            fail_count++;
            $error("Error at time %0t: choice_b_g is %0b, expected %0b", $time,
                   $sampled(choice_b_g), $sampled(exp_choice));
        end

endmodule

bind bp_top bp_asserts u_asserts (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_gh_hashed    (pc_gh_hashed),
    .pc_bh_hashed    (pc_bh_hashed),
    .kind_pdc        (kind_pdc),
    .pc_ex_gh_hashed (pc_ex_gh_hashed),
    .pc_ex_bh_hashed (pc_ex_bh_hashed),
    .kind_ex         (kind_ex),
    .choice_real     (choice_real),
    .taken_real      (taken_real),
    .update_en       (update_en),
    .taken_pdc       (taken_pdc),
    .choice_b_g      (choice_b_g),
    .ready           (ready)
);

/* tb_bp.sv */
`timescale 1ns/10ps
`include "bp_settings.svh"

module tb_bp;
    import bp_pkg::*;

    localparam int sweep_cycles    = 1 << `BP_SWEEP_WIDTH;
    localparam int n_random        = 600;
    localparam int directed_cycles = sweep_cycles + 64;
    // reset + sweep + directed + random + margin
    localparam int cycle_limit = 8 + sweep_cycles + directed_cycles + n_random + 100;

    logic                      clk;
    logic                      rst_n;
    logic [`BP_ADDR_WIDTH-1:0] pc;
    logic [`BP_GH_WIDTH-1:0]   pc_gh_hashed;
    logic [`BP_BH_WIDTH-1:0]   pc_bh_hashed;
    br_kind_e                  kind_pdc;
    logic [`BP_ADDR_WIDTH-1:0] pc_ex;
    logic [`BP_GH_WIDTH-1:0]   pc_ex_gh_hashed;
    logic [`BP_BH_WIDTH-1:0]   pc_ex_bh_hashed;
    br_kind_e                  kind_ex;
    logic                      choice_real;
    logic                      taken_real;
    logic                      update_en;
    logic                      taken_pdc;
    logic                      choice_b_g;
    logic                      ready;

    logic [31:0] rng_state;
    int          cycle_cnt;

    bp_top u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .pc              (pc),
        .pc_gh_hashed    (pc_gh_hashed),
        .pc_bh_hashed    (pc_bh_hashed),
        .kind_pdc        (kind_pdc),
        .pc_ex           (pc_ex),
        .pc_ex_gh_hashed (pc_ex_gh_hashed),
        .pc_ex_bh_hashed (pc_ex_bh_hashed),
        .kind_ex         (kind_ex),
        .choice_real     (choice_real),
        .taken_real      (taken_real),
        .update_en       (update_en),
        .taken_pdc       (taken_pdc),
        .choice_b_g      (choice_b_g),
        .ready           (ready)
    );

    // 8 ns period
    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // inputs move 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // one accepted direct-branch update
    task automatic train(input int gh, input int bh, input logic taken, input logic choice);
        pc_ex_gh_hashed = gh;
        pc_ex_bh_hashed = bh;
        kind_ex         = DIRECT_JUMP;
        taken_real      = taken;
        choice_real     = choice;
        update_en       = 1'b1;
        next_cycle();
        update_en = 1'b0;
    endtask

    task automatic predict(input int gh, input int bh, input br_kind_e kind);
        pc_gh_hashed = gh;
        pc_bh_hashed = bh;
        kind_pdc     = kind;
        next_cycle();
    endtask

    // small index range so updates and lookups collide often
    task automatic drive_random();
        logic [31:0] r1;
        logic [31:0] r2;
        rng_state       = lcg_next(rng_state);
        r1              = rng_state;
        rng_state       = lcg_next(rng_state);
        r2              = rng_state;
        pc              = r1[31:2];
        pc_gh_hashed    = r1[28:24];
        pc_bh_hashed    = r1[20:16];
        kind_pdc        = br_kind_e'(r1[14:12]);
        pc_ex           = r2[31:2];
        pc_ex_gh_hashed = r2[28:24];
        pc_ex_bh_hashed = r2[20:16];
        kind_ex         = r2[15] ? DIRECT_JUMP : br_kind_e'(r2[14:12]);
        update_en       = r2[11] | r2[10];
        taken_real      = r2[9];
        choice_real     = r2[8];
    endtask

    // timeout and assertion watch
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (u_dut.u_asserts.fail_count != 0) begin
            $display("an assertion on the predictor outputs failed");
            $display("Result: FAILED");
            $fatal(1, "stopped on the first assertion failure");
        end else if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $fatal(1, "stopped on timeout");
        end
    end

    initial begin
        rng_state       = 32'hdd7;
        cycle_cnt       = 0;
        rst_n           = 1'b0;
        pc              = '0;
        pc_gh_hashed    = '0;
        pc_bh_hashed    = '0;
        kind_pdc        = NOT_JUMP;
        pc_ex           = '0;
        pc_ex_gh_hashed = '0;
        pc_ex_bh_hashed = '0;
        kind_ex         = NOT_JUMP;
        choice_real     = 1'b0;
        taken_real      = 1'b0;
        update_en       = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // direct updates during the sweep must be dropped
        while (ready !== 1'b1) begin
            drive_random();
            kind_ex   = DIRECT_JUMP;
            update_en = 1'b1;
            next_cycle();
        end
        update_en = 1'b0;

        // every index weakly not taken, weakly bimodal
        for (int i = 0; i < sweep_cycles; i++) begin
            predict(i, i, DIRECT_JUMP);
        end

        // fixed kinds, code 7 included as unknown
        for (int k = 0; k < 8; k++) begin
            predict(3, 3, br_kind_e'(k));
        end

        // bimodal taken after two updates, then saturate and step back
        train(9, 5, 1'b1, 1'b0);
        train(9, 5, 1'b1, 1'b0);
        predict(9, 5, DIRECT_JUMP);
        repeat (3) train(9, 5, 1'b1, 1'b0);
        predict(9, 5, DIRECT_JUMP);
        train(9, 5, 1'b0, 1'b0);
        predict(9, 5, DIRECT_JUMP);

        // choice flips to global, bimodal left untrained at index 41
        train(20, 40, 1'b1, 1'b1);
        train(20, 40, 1'b1, 1'b1);
        predict(20, 41, DIRECT_JUMP);
        // global goes not taken while bimodal 40 stays taken
        train(20, 42, 1'b0, 1'b1);
        train(20, 42, 1'b0, 1'b1);
        predict(20, 40, DIRECT_JUMP);

        // mixed traffic against the shadow tables
        repeat (n_random) begin
            drive_random();
            next_cycle();
        end
        update_en = 1'b0;
        next_cycle();
        next_cycle();

        if (u_dut.u_asserts.fail_count != 0) begin
            $display("an assertion on the predictor outputs failed");
            $display("Result: FAILED");
            $fatal(1, "assertion failures at end of run");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* bp.f */
+incdir+.
bp_pkg.sv
bp_pht.sv
bp_sweep_counter.sv
bp_init_fsm.sv
aim_predictor.sv
bp_top.sv
bp_asserts.sv
tb_bp.sv

/* Bender.yml */
package:
  name: bp

sources:
  - include_dirs:
      - .
    files:
      - bp_pkg.sv
      - bp_pht.sv
      - bp_sweep_counter.sv
      - bp_init_fsm.sv
      - aim_predictor.sv
      - bp_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - bp_asserts.sv
      - tb_bp.sv
